// File: src/soc_consts.svh
// Address map and register offsets of the SoC fabric
// Area prefix is mem_addr[31:30], core prefix is mem_addr[29:24]
// Areas 0 and 2 and unlisted core prefixes are unmapped and read zero
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Address field positions
`define AREA_MSB 31
`define AREA_LSB 30
`define CORE_MSB 29
`define CORE_LSB 24
`define WORD_LSB 2
`define REG_ADDR_MSB 9

// Area and core prefixes
`define AREA_RAM 2'h1
`define AREA_MMIO 2'h3
`define CORE_TIMER 6'h01
`define CORE_FW_RAM 6'h10
`define CORE_SYS_CTRL 6'h3f

// Memory sizes in address bits of 32-bit words
`define RAM_ADDR_BITS 10
`define FW_RAM_ADDR_BITS 6

// Timer register offsets
`define TMR_CTRL 8'h00
`define TMR_STATUS 8'h01
`define TMR_PRESCALER 8'h02
`define TMR_VALUE 8'h03

// System control register offsets
`define SYS_NAME 8'h00
`define SYS_APP_MODE 8'h01
`define SYS_LED 8'h02
`define SYS_NAME_VALUE 32'h736f6331

`endif

// File: src/soc_pkg.sv
// Shared bus types of the SoC fabric
// Area enum values follow the prefixes in soc_consts.svh
`include "soc_consts.svh"

package soc_pkg;

  typedef logic [31:0] bus_word_t;
  typedef logic [3:0]  strobe_t;

  // Word address inside a register core, mem_addr[9:2]
  typedef logic [7:0]  reg_addr_t;

  // Areas 0 and 2 are not mapped in this fabric
  typedef enum logic [1:0] {
    AREA_BOOT = 2'h0,
    AREA_SRAM = `AREA_RAM,
    AREA_RSVD = 2'h2,
    AREA_IO   = `AREA_MMIO
  } area_e;

endpackage

// File: src/mem_decoder.sv
// Address decoder and read mux for the single-word valid/ready bus
// Read data and ready are registered, so every access takes at least 1 cycle
// Unmapped areas and core prefixes complete at once and read zero
`timescale 1ns/1ns
`include "soc_consts.svh"

module mem_decoder (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            mem_valid,
  input  soc_pkg::bus_word_t              mem_addr,
  input  soc_pkg::bus_word_t              mem_wdata,
  input  soc_pkg::strobe_t                mem_wstrb,
  output logic                            mem_ready,
  output soc_pkg::bus_word_t              mem_rdata,
  output logic                            ram_cs,
  output soc_pkg::strobe_t                ram_we,
  output logic [`RAM_ADDR_BITS-1:0]       ram_address,
  output soc_pkg::bus_word_t              ram_write_data,
  input  soc_pkg::bus_word_t              ram_read_data,
  input  logic                            ram_ready,
  output logic                            fw_ram_cs,
  output soc_pkg::strobe_t                fw_ram_we,
  output logic [`FW_RAM_ADDR_BITS-1:0]    fw_ram_address,
  output soc_pkg::bus_word_t              fw_ram_write_data,
  input  soc_pkg::bus_word_t              fw_ram_read_data,
  input  logic                            fw_ram_ready,
  output logic                            timer_cs,
  output logic                            timer_we,
  output soc_pkg::reg_addr_t              timer_address,
  output soc_pkg::bus_word_t              timer_write_data,
  input  soc_pkg::bus_word_t              timer_read_data,
  input  logic                            timer_ready,
  output logic                            sys_ctrl_cs,
  output logic                            sys_ctrl_we,
  output soc_pkg::reg_addr_t              sys_ctrl_address,
  output soc_pkg::bus_word_t              sys_ctrl_write_data,
  input  soc_pkg::bus_word_t              sys_ctrl_read_data,
  input  logic                            sys_ctrl_ready
);
  import soc_pkg::*;

  area_e      area;
  logic [5:0] core;
  reg_addr_t  reg_addr;
  logic       pending;
  bus_word_t  rdata_new;
  logic       ready_new;

  assign area     = area_e'(mem_addr[`AREA_MSB:`AREA_LSB]);
  assign core     = mem_addr[`CORE_MSB:`CORE_LSB];
  assign reg_addr = mem_addr[`REG_ADDR_MSB:`WORD_LSB];

  // Request seen but not yet answered
  assign pending = mem_valid && !mem_ready;

  // Address, data and write enables fan out to all cores
  assign ram_we              = mem_wstrb;
  assign ram_address         = mem_addr[`RAM_ADDR_BITS+`WORD_LSB-1:`WORD_LSB];
  assign ram_write_data      = mem_wdata;
  assign fw_ram_we           = mem_wstrb;
  assign fw_ram_address      = mem_addr[`FW_RAM_ADDR_BITS+`WORD_LSB-1:`WORD_LSB];
  assign fw_ram_write_data   = mem_wdata;
  assign timer_we            = |mem_wstrb;
  assign timer_address       = reg_addr;
  assign timer_write_data    = mem_wdata;
  assign sys_ctrl_we         = |mem_wstrb;
  assign sys_ctrl_address    = reg_addr;
  assign sys_ctrl_write_data = mem_wdata;

  // --------------------
  // Chip select and read mux
  // --------------------
  always_comb begin
    ram_cs      = 1'b0;
    fw_ram_cs   = 1'b0;
    timer_cs    = 1'b0;
    sys_ctrl_cs = 1'b0;
    rdata_new   = '0;
    ready_new   = 1'b0;
    if (pending) begin
      case (area)
        AREA_SRAM: begin
          ram_cs    = 1'b1;
          rdata_new = ram_read_data;
          ready_new = ram_ready;
        end
        AREA_IO: begin
          case (core)
            `CORE_TIMER: begin
              timer_cs  = 1'b1;
              rdata_new = timer_read_data;
              ready_new = timer_ready;
            end
            `CORE_FW_RAM: begin
              fw_ram_cs = 1'b1;
              rdata_new = fw_ram_read_data;
              ready_new = fw_ram_ready;
            end
            `CORE_SYS_CTRL: begin
              sys_ctrl_cs = 1'b1;
              rdata_new   = sys_ctrl_read_data;
              ready_new   = sys_ctrl_ready;
            end
            // Unused core prefix
            default: ready_new = 1'b1;
          endcase
        end
        AREA_BOOT, AREA_RSVD: ready_new = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_rdata <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_rdata <= rdata_new;
      mem_ready <= ready_new;
    end
  end

endmodule

// File: src/ram.sv
// Main RAM, 2^RAM_ADDR_BITS words with byte write strobes
// Read data and ready are registered, one cycle after cs
// Contents are not cleared by reset
`timescale 1ns/1ns
`include "soc_consts.svh"

module ram (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      cs,
  input  soc_pkg::strobe_t          we,
  input  logic [`RAM_ADDR_BITS-1:0] address,
  input  soc_pkg::bus_word_t        write_data,
  output soc_pkg::bus_word_t        read_data,
  output logic                      ready
);
  import soc_pkg::*;

  bus_word_t mem [2**`RAM_ADDR_BITS];

  // Byte lanes written independently
  always_ff @(posedge clk) begin
    if (cs) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) begin
          mem[address][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
      read_data <= mem[address];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

endmodule

// File: src/fw_ram.sv
// Firmware RAM with combinational read and byte write strobes
// Locked once fw_app_mode is set: writes dropped, reads return zero
// ready follows cs even when locked so the bus never stalls
`timescale 1ns/1ns
`include "soc_consts.svh"

module fw_ram (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         fw_app_mode,
  input  logic                         cs,
  input  soc_pkg::strobe_t             we,
  input  logic [`FW_RAM_ADDR_BITS-1:0] address,
  input  soc_pkg::bus_word_t           write_data,
  output soc_pkg::bus_word_t           read_data,
  output logic                         ready
);
  import soc_pkg::*;

  bus_word_t mem [2**`FW_RAM_ADDR_BITS];
  logic      wr_allowed;

  // No writes while in reset or after the lock
  assign wr_allowed = reset_n && cs && !fw_app_mode;

  always_ff @(posedge clk) begin
    if (wr_allowed) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) begin
          mem[address][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
  end

  // Locked contents are hidden from reads
  always_comb begin
    if (fw_app_mode) begin
      read_data = '0;
    end else begin
      read_data = mem[address];
    end
  end

  assign ready = cs;

endmodule

// File: src/timer.sv
// Countdown timer, VALUE decrements once every PRESCALER+1 cycles
// CTRL bit 0 starts, bit 1 stops (stop wins); STATUS bit 0 is running
// Stops itself when VALUE reaches zero; VALUE is read-only while running
`timescale 1ns/1ns
`include "soc_consts.svh"

module timer (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  logic               we,
  input  soc_pkg::reg_addr_t address,
  input  soc_pkg::bus_word_t write_data,
  output soc_pkg::bus_word_t read_data,
  output logic               ready
);
  import soc_pkg::*;

  logic      running;
  bus_word_t prescaler_reg;
  bus_word_t value_reg;
  bus_word_t presc_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running       <= 1'b0;
      prescaler_reg <= '0;
      value_reg     <= '0;
      presc_cnt     <= '0;
    end else begin
      // --------------------
      // Countdown
      // --------------------
      if (running) begin
        if (value_reg == '0) begin
          running <= 1'b0;
        end else if (presc_cnt >= prescaler_reg) begin
          presc_cnt <= '0;
          value_reg <= value_reg - 1'b1;
          if (value_reg == 32'h1) begin
            running <= 1'b0;
          end
        end else begin
          presc_cnt <= presc_cnt + 1'b1;
        end
      end

      // Bus writes take priority over the countdown
      if (cs && we) begin
        case (address)
          `TMR_CTRL: begin
            if (write_data[1]) begin
              running <= 1'b0;
            end else if (write_data[0]) begin
              running   <= 1'b1;
              presc_cnt <= '0;
            end
          end
          `TMR_PRESCALER: prescaler_reg <= write_data;
          `TMR_VALUE: begin
            if (!running) begin
              value_reg <= write_data;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (address)
      `TMR_STATUS:    read_data = {31'h0, running};
      `TMR_PRESCALER: read_data = prescaler_reg;
      `TMR_VALUE:     read_data = value_reg;
      // CTRL is write-only
      default:        read_data = '0;
    endcase
  end

  assign ready = cs;

endmodule

// File: src/sys_ctrl.sv
// System control core with identification word, app mode flag and LEDs
// App mode is sticky: any write sets it and only reset clears it
`timescale 1ns/1ns
`include "soc_consts.svh"

module sys_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  logic               we,
  input  soc_pkg::reg_addr_t address,
  input  soc_pkg::bus_word_t write_data,
  output soc_pkg::bus_word_t read_data,
  output logic               ready,
  output logic               fw_app_mode,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);
  import soc_pkg::*;

  logic [2:0] led_reg;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_app_mode <= 1'b0;
      led_reg     <= 3'b000;
    end else if (cs && we) begin
      if (address == `SYS_APP_MODE) begin
        fw_app_mode <= 1'b1;
      end
      if (address == `SYS_LED) begin
        led_reg <= write_data[2:0];
      end
    end
  end

  always_comb begin
    case (address)
      `SYS_NAME:     read_data = `SYS_NAME_VALUE;
      `SYS_APP_MODE: read_data = {31'h0, fw_app_mode};
      `SYS_LED:      read_data = {29'h0, led_reg};
      default:       read_data = '0;
    endcase
  end

  // Bit 2 red, bit 1 green, bit 0 blue
  assign led_r = led_reg[2];
  assign led_g = led_reg[1];
  assign led_b = led_reg[0];
  assign ready = cs;

endmodule

// File: src/app_soc_top.sv
// SoC fabric top level, the bus master sits outside
// Connects the decoder to main RAM, firmware RAM, timer and system control
`timescale 1ns/1ns
`include "soc_consts.svh"

module app_soc_top (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               mem_valid,
  output logic               mem_ready,
  input  soc_pkg::bus_word_t mem_addr,
  input  soc_pkg::bus_word_t mem_wdata,
  input  soc_pkg::strobe_t   mem_wstrb,
  output soc_pkg::bus_word_t mem_rdata,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);
  import soc_pkg::*;

  logic                         ram_cs, ram_ready;
  strobe_t                      ram_we;
  logic [`RAM_ADDR_BITS-1:0]    ram_address;
  bus_word_t                    ram_write_data, ram_read_data;

  logic                         fw_ram_cs, fw_ram_ready, fw_app_mode;
  strobe_t                      fw_ram_we;
  logic [`FW_RAM_ADDR_BITS-1:0] fw_ram_address;
  bus_word_t                    fw_ram_write_data, fw_ram_read_data;

  logic                         timer_cs, timer_we, timer_ready;
  reg_addr_t                    timer_address;
  bus_word_t                    timer_write_data, timer_read_data;

  logic                         sys_ctrl_cs, sys_ctrl_we, sys_ctrl_ready;
  reg_addr_t                    sys_ctrl_address;
  bus_word_t                    sys_ctrl_write_data, sys_ctrl_read_data;

  mem_decoder decoder_inst (.*);

  ram ram_inst (
    .clk, .reset_n, .cs(ram_cs), .we(ram_we), .address(ram_address),
    .write_data(ram_write_data), .read_data(ram_read_data), .ready(ram_ready)
  );

  // Locked by the app mode flag from system control
  fw_ram fw_ram_inst (
    .clk, .reset_n, .fw_app_mode, .cs(fw_ram_cs), .we(fw_ram_we),
    .address(fw_ram_address), .write_data(fw_ram_write_data),
    .read_data(fw_ram_read_data), .ready(fw_ram_ready)
  );

  timer timer_inst (
    .clk, .reset_n, .cs(timer_cs), .we(timer_we), .address(timer_address),
    .write_data(timer_write_data), .read_data(timer_read_data), .ready(timer_ready)
  );

  sys_ctrl sys_ctrl_inst (
    .clk, .reset_n, .cs(sys_ctrl_cs), .we(sys_ctrl_we), .address(sys_ctrl_address),
    .write_data(sys_ctrl_write_data), .read_data(sys_ctrl_read_data),
    .ready(sys_ctrl_ready), .fw_app_mode, .led_r, .led_g, .led_b
  );

endmodule

// File: dv/app_soc_tb.sv
// Self-checking testbench for the SoC fabric that acts as the bus master
// Main RAM and firmware RAM are filled with full-word writes before any readback
// Timer VALUE is checked inline against the timer rules
`timescale 1ns/1ns
`include "soc_consts.svh"

module app_soc_tb;
  import soc_pkg::*;

  logic      clk;
  logic      reset_n;
  logic      mem_valid;
  logic      mem_ready;
  bus_word_t mem_addr;
  bus_word_t mem_wdata;
  strobe_t   mem_wstrb;
  bus_word_t mem_rdata;
  logic      led_r;
  logic      led_g;
  logic      led_b;

  // Shadow model of the address map
  bus_word_t  ram_m [2**`RAM_ADDR_BITS];
  bus_word_t  fw_m [2**`FW_RAM_ADDR_BITS];
  logic       app_mode_m;
  logic [2:0] led_m;

  int          errors = 0;
  int          checks = 0;
  int          test_base = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int unsigned cycle_cnt = 0;

  // Pending read for the compare process
  logic      cmp_pending = 1'b0;
  bus_word_t cmp_addr;
  bus_word_t cmp_got;
  bus_word_t cmp_exp;

  app_soc_top dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycle_cnt++;

  // --------------------
  // Reference model
  // --------------------
  function automatic bus_word_t merge_bytes(bus_word_t old, bus_word_t data, strobe_t strb);
    bus_word_t result;
    result = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = data[8*i +: 8];
      end
    end
    return result;
  endfunction

  function automatic bus_word_t model_read(bus_word_t addr);
    bus_word_t result;
    result = '0;
    if (addr[31:30] == `AREA_RAM) begin
      result = ram_m[addr[11:2]];
    end else if (addr[31:30] == `AREA_MMIO) begin
      if (addr[29:24] == `CORE_FW_RAM && !app_mode_m) begin
        result = fw_m[addr[7:2]];
      end else if (addr[29:24] == `CORE_SYS_CTRL) begin
        case (addr[9:2])
          `SYS_NAME:     result = `SYS_NAME_VALUE;
          `SYS_APP_MODE: result = {31'h0, app_mode_m};
          `SYS_LED:      result = {29'h0, led_m};
          default:       result = '0;
        endcase
      end
    end
    return result;
  endfunction

  task automatic model_write(bus_word_t addr, bus_word_t data, strobe_t strb);
    if (addr[31:30] == `AREA_RAM) begin
      ram_m[addr[11:2]] = merge_bytes(ram_m[addr[11:2]], data, strb);
    end else if (addr[31:30] == `AREA_MMIO) begin
      if (addr[29:24] == `CORE_FW_RAM && !app_mode_m) begin
        fw_m[addr[7:2]] = merge_bytes(fw_m[addr[7:2]], data, strb);
      end else if (addr[29:24] == `CORE_SYS_CTRL) begin
        if (addr[9:2] == `SYS_APP_MODE) begin
          app_mode_m = 1'b1;
        end
        if (addr[9:2] == `SYS_LED) begin
          led_m = data[2:0];
        end
      end
    end
  endtask

  function automatic bus_word_t mmio_addr(logic [5:0] core, logic [7:0] word);
    return {`AREA_MMIO, core, 14'h0, word, 2'b00};
  endfunction

  // --------------------
  // Bus tasks
  // --------------------
  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic check_word(string name, bus_word_t got, bus_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic wait_ready(bus_word_t addr);
    int cycles;
    int exp_cycles;
    cycles = 0;
    exp_cycles = (addr[31:30] == `AREA_RAM) ? 2 : 1;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!mem_ready && cycles < 50);
    if (!mem_ready) begin
      abort_run($sformatf("No mem_ready within 50 cycles for address %h", addr));
    end else begin
      checks++;
      if (cycles != exp_cycles) begin
        errors++;
        $display("FAILED t=%0t mem_ready latency addr=%h got=%0d exp=%0d",
                 $time, addr, cycles, exp_cycles);
      end
    end
  endtask

  task automatic bus_write(bus_word_t addr, bus_word_t data, strobe_t strb);
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    wait_ready(addr);
    mem_valid = 1'b0;
    mem_wstrb = '0;
    model_write(addr, data, strb);
  endtask

  task automatic bus_read(bus_word_t addr, output bus_word_t data, input bit compare);
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wstrb = '0;
    wait_ready(addr);
    data      = mem_rdata;
    mem_valid = 1'b0;
    if (compare) begin
      cmp_addr    = addr;
      cmp_got     = data;
      cmp_exp     = model_read(addr);
      cmp_pending = 1'b1;
    end
  endtask

  task automatic end_test(string name);
    @(posedge clk);
    #1;
    tests_run++;
    if (errors == test_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // Compares each captured read against the model
  always @(posedge clk) begin
    if (cmp_pending) begin
      checks++;
      if (cmp_got !== cmp_exp) begin
        errors++;
        $display("FAILED t=%0t mem_rdata addr=%h got=%h exp=%h",
                 $time, cmp_addr, cmp_got, cmp_exp);
      end
      cmp_pending = 1'b0;
    end
  end

  initial begin
    bus_word_t   addr;
    bus_word_t   data;
    bus_word_t   rd;
    bus_word_t   prev;
    bus_word_t   unmapped [6];
    int unsigned presc;
    int unsigned val;
    int unsigned limit;
    int unsigned start_cycle;
    bit          done;

    void'($urandom(32'h6cc5aebc));
    clk        = 1'b0;
    reset_n    = 1'b0;
    mem_valid  = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = '0;
    app_mode_m = 1'b0;
    led_m      = 3'b000;
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;

    check_word("mem_ready", mem_ready, 0);
    check_word("mem_rdata", mem_rdata, 0);
    check_word("led rgb", {led_r, led_g, led_b}, 0);
    end_test("reset");

    // Fill so that partial-strobe writes merge into known words
    for (int i = 0; i < 2**`RAM_ADDR_BITS; i++) begin
      bus_write({`AREA_RAM, 18'h0, i[9:0], 2'b00}, i * 32'h9e3779b9 + 32'h1357, 4'hf);
    end
    for (int i = 0; i < 64; i++) begin
      addr = {$urandom()};
      addr = {`AREA_RAM, addr[27:0], 2'b00};
      bus_write(addr, $urandom(), strobe_t'($urandom_range(15, 1)));
      bus_read(addr, rd, 1'b1);
      addr = {$urandom()};
      bus_read({`AREA_RAM, addr[27:0], 2'b00}, rd, 1'b1);
    end
    end_test("ram");

    unmapped[0] = {2'h0, 30'($urandom())};
    unmapped[1] = {2'h2, 30'($urandom())};
    unmapped[2] = mmio_addr(6'h00, 8'h01);
    unmapped[3] = mmio_addr(6'h02, 8'h00);
    unmapped[4] = mmio_addr(6'h20, 8'h03);
    unmapped[5] = mmio_addr(6'h3e, 8'h02);
    foreach (unmapped[i]) begin
      bus_write(unmapped[i], $urandom(), 4'hf);
      bus_read(unmapped[i], rd, 1'b1);
    end
    end_test("unmapped");

    for (int i = 0; i < 64; i++) begin
      bus_write(mmio_addr(`CORE_FW_RAM, i[7:0]), i * 32'h2545f491 + 32'h0bad, 4'hf);
    end
    for (int i = 0; i < 48; i++) begin
      addr = mmio_addr(`CORE_FW_RAM, 8'($urandom_range(63, 0)));
      bus_write(addr, $urandom(), strobe_t'($urandom_range(15, 1)));
      bus_read(addr, rd, 1'b1);
    end
    end_test("fw_ram");

    // --------------------
    // Timer countdown
    // --------------------
    presc = $urandom_range(3, 0);
    val   = $urandom_range(20, 5);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_PRESCALER), presc, 4'hf);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_VALUE), val, 4'hf);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_PRESCALER), rd, 1'b0);
    check_word("timer prescaler", rd, presc);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), rd, 1'b0);
    check_word("timer value", rd, val);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_CTRL), 32'h1, 4'hf);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_STATUS), rd, 1'b0);
    check_word("timer status", rd, 1);
    start_cycle = cycle_cnt;
    limit = (val + 1) * (presc + 1) + 50;
    prev  = val;
    done  = 1'b0;
    while (!done && cycle_cnt - start_cycle < limit) begin
      bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), rd, 1'b0);
      checks++;
      if (rd > prev) begin
        errors++;
        $display("FAILED t=%0t timer value rose got=%h prev=%h", $time, rd, prev);
      end
      prev = rd;
      bus_read(mmio_addr(`CORE_TIMER, `TMR_STATUS), rd, 1'b0);
      done = (rd[0] == 1'b0);
    end
    if (!done) begin
      errors++;
      $display("Timer still running after %0d cycles", limit);
    end
    bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), rd, 1'b0);
    check_word("timer value", rd, 0);

    // Stop freezes a second countdown
    bus_write(mmio_addr(`CORE_TIMER, `TMR_PRESCALER), 32'h1, 4'hf);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_VALUE), 32'd200, 4'hf);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_CTRL), 32'h1, 4'hf);
    repeat (20) @(posedge clk);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_STATUS), rd, 1'b0);
    check_word("timer status", rd, 1);
    bus_write(mmio_addr(`CORE_TIMER, `TMR_CTRL), 32'h2, 4'hf);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), prev, 1'b0);
    repeat (30) @(posedge clk);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), rd, 1'b0);
    check_word("timer value", rd, prev);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_STATUS), rd, 1'b0);
    check_word("timer status", rd, 0);
    end_test("timer");

    bus_read(mmio_addr(`CORE_SYS_CTRL, `SYS_NAME), rd, 1'b1);
    for (int i = 0; i < 4; i++) begin
      bus_write(mmio_addr(`CORE_SYS_CTRL, `SYS_LED), $urandom(), 4'hf);
      check_word("led_r", led_r, led_m[2]);
      check_word("led_g", led_g, led_m[1]);
      check_word("led_b", led_b, led_m[0]);
      bus_read(mmio_addr(`CORE_SYS_CTRL, `SYS_LED), rd, 1'b1);
    end
    bus_read(mmio_addr(`CORE_SYS_CTRL, `SYS_APP_MODE), rd, 1'b1);
    bus_write(mmio_addr(`CORE_SYS_CTRL, `SYS_APP_MODE), $urandom(), 4'hf);
    bus_read(mmio_addr(`CORE_SYS_CTRL, `SYS_APP_MODE), rd, 1'b1);
    for (int i = 0; i < 8; i++) begin
      addr = mmio_addr(`CORE_FW_RAM, 8'($urandom_range(63, 0)));
      bus_read(addr, rd, 1'b1);
      bus_write(addr, $urandom(), 4'hf);
      bus_read(addr, rd, 1'b1);
      data = {$urandom()};
      addr = {`AREA_RAM, data[27:0], 2'b00};
      bus_write(addr, $urandom(), strobe_t'($urandom_range(15, 1)));
      bus_read(addr, rd, 1'b1);
    end

    // Reset clears the lock and keeps the firmware RAM contents
    @(posedge clk);
    #1;
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset_n    = 1'b1;
    app_mode_m = 1'b0;
    led_m      = 3'b000;
    check_word("led rgb", {led_r, led_g, led_b}, 0);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_STATUS), rd, 1'b0);
    check_word("timer status", rd, 0);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_PRESCALER), rd, 1'b0);
    check_word("timer prescaler", rd, 0);
    bus_read(mmio_addr(`CORE_TIMER, `TMR_VALUE), rd, 1'b0);
    check_word("timer value", rd, 0);
    bus_read(mmio_addr(`CORE_SYS_CTRL, `SYS_APP_MODE), rd, 1'b1);
    for (int i = 0; i < 64; i++) begin
      bus_read(mmio_addr(`CORE_FW_RAM, i[7:0]), rd, 1'b1);
    end
    end_test("sys_ctrl");

    repeat (2) @(posedge clk);
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/soc_pkg.sv
src/mem_decoder.sv
src/ram.sv
src/fw_ram.sv
src/timer.sv
src/sys_ctrl.sv
src/app_soc_top.sv
dv/app_soc_tb.sv
